//--- common/wh_pkg.sv
// wormhole router shared definitions
package wh_pkg;

  // port count and direction indices
  localparam int NUM_DIRS = 3;
  localparam int DIR_P = 0;
  localparam int DIR_W = 1;
  localparam int DIR_E = 2;

  // width of a direction index, used by the arbiter pointer
  localparam int DIR_IDX_W = 2;

  // flit field widths
  localparam int X_W = 4;
  localparam int LEN_W = 4;
  localparam int PAYLOAD_W = 8;
  localparam int FLIT_W = X_W + LEN_W + PAYLOAD_W;

  // one flit, dest_x in the top bits
  // header: len is the number of body flits that follow
  // body: dest_x and len carry free data
  typedef struct packed {
    logic [X_W-1:0]       dest_x;
    logic [LEN_W-1:0]     len;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // one bit per direction, for routes, requests and grants
  typedef logic [NUM_DIRS-1:0] dir_mask_t;

  // one flit per direction
  typedef flit_t [NUM_DIRS-1:0] flit_vec_t;

endpackage

//--- hdl/wh_two_fifo.sv
// two-entry flit buffer
`timescale 1ns/1ps

module wh_two_fifo (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           valid_i,
  input  wh_pkg::flit_t  data_i,
  output logic           ready_o,
  output logic           valid_o,
  output wh_pkg::flit_t  data_o,
  input  logic           yumi_i
);

  // two flit slots and their pointers
  logic [wh_pkg::FLIT_W-1:0] mem_q [2];
  logic rd_ptr_q;
  logic wr_ptr_q;
  logic empty_q;
  logic full_q;
  logic enq;
  logic deq;

  assign ready_o = ~full_q;
  assign valid_o = ~empty_q;
  assign data_o  = wh_pkg::flit_t'(mem_q[rd_ptr_q]);

  assign enq = valid_i & ~full_q;
  assign deq = yumi_i & ~empty_q;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      empty_q  <= 1'b1;
      full_q   <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (deq) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // occupancy only changes when exactly one side moves
      if (enq && !deq) begin
        empty_q <= 1'b0;
        full_q  <= ~empty_q;
      end else if (deq && !enq) begin
        full_q  <= 1'b0;
        empty_q <= ~full_q;
      end
    end
  end

endmodule

//--- wh_input/wh_input_port.sv
// router input port
`timescale 1ns/1ps

module wh_input_port (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [wh_pkg::X_W-1:0] local_x_i,
  input  logic                   in_valid_i,
  input  wh_pkg::flit_t          in_data_i,
  output logic                   in_ready_o,
  output logic                   head_valid_o,
  output wh_pkg::flit_t          head_data_o,
  output wh_pkg::dir_mask_t      route_o,
  input  logic                   pop_i
);

  logic [wh_pkg::LEN_W-1:0] body_cnt_q;
  wh_pkg::dir_mask_t        route_q;
  wh_pkg::dir_mask_t        head_route;
  logic                     is_header;

  wh_two_fifo u_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (in_valid_i),
    .data_i   (in_data_i),
    .ready_o  (in_ready_o),
    .valid_o  (head_valid_o),
    .data_o   (head_data_o),
    .yumi_i   (pop_i)
  );

  // no body flits pending, so the head is a header
  assign is_header = (body_cnt_q == '0);

  // x routing against the local coordinate
  always_comb begin
    head_route = '0;
    if (head_data_o.dest_x == local_x_i) begin
      head_route[wh_pkg::DIR_P] = 1'b1;
    end else if (head_data_o.dest_x < local_x_i) begin
      head_route[wh_pkg::DIR_W] = 1'b1;
    end else begin
      head_route[wh_pkg::DIR_E] = 1'b1;
    end
  end

  // body flits follow the route taken by their header
  assign route_o = is_header ? head_route : route_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      body_cnt_q <= '0;
      route_q    <= '0;
    end else if (pop_i) begin
      if (is_header) begin
        body_cnt_q <= head_data_o.len;
        route_q    <= head_route;
      end else begin
        body_cnt_q <= body_cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- wh_output/wh_rr_arb.sv
// round-robin arbiter
`timescale 1ns/1ps

module wh_rr_arb (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  wh_pkg::dir_mask_t req_i,
  input  logic              advance_i,
  output wh_pkg::dir_mask_t grant_o
);

  logic [wh_pkg::DIR_IDX_W-1:0] ptr_q;
  logic [wh_pkg::DIR_IDX_W-1:0] next_ptr;

  // first request at or after the pointer, wrapping around
  always_comb begin
    int idx;
    logic found;
    grant_o  = '0;
    next_ptr = ptr_q;
    found    = 1'b0;
    for (int k = 0; k < wh_pkg::NUM_DIRS; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= wh_pkg::NUM_DIRS) begin
        idx = idx - wh_pkg::NUM_DIRS;
      end
      if (!found && req_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        // winner gets lowest priority next round
        if (idx == wh_pkg::NUM_DIRS - 1) begin
          next_ptr = '0;
        end else begin
          next_ptr = wh_pkg::DIR_IDX_W'(idx + 1);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= wh_pkg::DIR_IDX_W'(wh_pkg::DIR_P);
    end else if (advance_i) begin
      ptr_q <= next_ptr;
    end
  end

endmodule

//--- wh_output/wh_output_port.sv
// router output port with wormhole lock
`timescale 1ns/1ps

module wh_output_port #(
  parameter int PORT = wh_pkg::DIR_P
) (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  wh_pkg::dir_mask_t                          head_valid_i,
  input  wh_pkg::flit_vec_t                          head_data_i,
  input  wh_pkg::dir_mask_t [wh_pkg::NUM_DIRS-1:0]   route_i,
  input  logic                                       out_ready_i,
  output logic                                       out_valid_o,
  output wh_pkg::flit_t                              out_data_o,
  output wh_pkg::dir_mask_t                          grant_o
);

  wh_pkg::dir_mask_t        req;
  wh_pkg::dir_mask_t        arb_req;
  wh_pkg::dir_mask_t        sel;
  wh_pkg::dir_mask_t        sel_q;
  logic                     busy_q;
  logic                     body_q;
  logic [wh_pkg::LEN_W-1:0] tail_cnt_q;
  logic [wh_pkg::FLIT_W-1:0] mux_data;
  logic                     xfer;

  // inputs with a head routed here, own input only on the P side
  always_comb begin
    for (int i = 0; i < wh_pkg::NUM_DIRS; i++) begin
      req[i] = head_valid_i[i] & route_i[i][PORT] &
               ((PORT == wh_pkg::DIR_P) || (i != PORT));
    end
  end

  // while held, only the held input may win
  assign arb_req = busy_q ? (req & sel_q) : req;

  wh_rr_arb u_arb (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (arb_req),
    .advance_i (xfer & ~body_q),
    .grant_o   (sel)
  );

  // one-hot data mux
  always_comb begin
    mux_data = '0;
    for (int i = 0; i < wh_pkg::NUM_DIRS; i++) begin
      if (sel[i]) begin
        mux_data = mux_data | head_data_i[i];
      end
    end
  end

  assign out_data_o  = wh_pkg::flit_t'(mux_data);
  assign out_valid_o = |sel;
  assign grant_o     = sel & {wh_pkg::NUM_DIRS{out_ready_i}};
  assign xfer        = out_valid_o & out_ready_i;

  // a stalled header also holds the choice, so valid and data stay put
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      body_q     <= 1'b0;
      tail_cnt_q <= '0;
      sel_q      <= '0;
    end else if (xfer) begin
      if (!body_q) begin
        // header leaves, lock until the tail unless header-only
        busy_q     <= (out_data_o.len != '0);
        body_q     <= (out_data_o.len != '0);
        tail_cnt_q <= out_data_o.len;
        sel_q      <= sel;
      end else begin
        tail_cnt_q <= tail_cnt_q - 1'b1;
        if (tail_cnt_q == wh_pkg::LEN_W'(1)) begin
          busy_q <= 1'b0;
          body_q <= 1'b0;
        end
      end
    end else if (out_valid_o && !busy_q) begin
      busy_q <= 1'b1;
      sel_q  <= sel;
    end
  end

endmodule

//--- hdl/wh_router_1d.sv
// one-dimensional wormhole router node
`timescale 1ns/1ps

module wh_router_1d (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [wh_pkg::X_W-1:0] local_x_i,
  input  wh_pkg::dir_mask_t      in_valid_i,
  input  wh_pkg::flit_vec_t      in_data_i,
  output wh_pkg::dir_mask_t      in_ready_o,
  output wh_pkg::dir_mask_t      out_valid_o,
  output wh_pkg::flit_vec_t      out_data_o,
  input  wh_pkg::dir_mask_t      out_ready_i
);

  wh_pkg::dir_mask_t                        head_valid;
  wh_pkg::flit_vec_t                        head_data;
  wh_pkg::dir_mask_t [wh_pkg::NUM_DIRS-1:0] route;
  wh_pkg::dir_mask_t [wh_pkg::NUM_DIRS-1:0] out_grant;
  wh_pkg::dir_mask_t                        pop;

  for (genvar i = 0; i < wh_pkg::NUM_DIRS; i++) begin : g_in
    wh_input_port u_in (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .local_x_i    (local_x_i),
      .in_valid_i   (in_valid_i[i]),
      .in_data_i    (in_data_i[i]),
      .in_ready_o   (in_ready_o[i]),
      .head_valid_o (head_valid[i]),
      .head_data_o  (head_data[i]),
      .route_o      (route[i]),
      .pop_i        (pop[i])
    );
  end

  for (genvar o = 0; o < wh_pkg::NUM_DIRS; o++) begin : g_out
    wh_output_port #(
      .PORT (o)
    ) u_out (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .head_valid_i (head_valid),
      .head_data_i  (head_data),
      .route_i      (route),
      .out_ready_i  (out_ready_i[o]),
      .out_valid_o  (out_valid_o[o]),
      .out_data_o   (out_data_o[o]),
      .grant_o      (out_grant[o])
    );
  end

  // an input pops when any output grants it
  always_comb begin
    pop = '0;
    for (int o = 0; o < wh_pkg::NUM_DIRS; o++) begin
      pop = pop | out_grant[o];
    end
  end

endmodule

//--- tests/wh_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module wh_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- tests/wh_router_asserts.sv
// output port checks
`timescale 1ns/1ps

module wh_router_asserts #(
  parameter int PORT = wh_pkg::DIR_P
) (
  input logic              clk_i,
  input logic              arst_n_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input wh_pkg::flit_t     out_data_i,
  input wh_pkg::dir_mask_t grant_i
);

  // a stalled flit stays offered and unchanged
  stall_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_data_i)))
    else $error("output %0d changed a stalled flit", PORT);

  grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grant_i))
    else $error("output %0d granted several inputs", PORT);

  // W and E never send a flit back where it came from
  no_own_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (PORT == wh_pkg::DIR_P) || !grant_i[PORT])
    else $error("output %0d granted its own input", PORT);

endmodule

//--- tests/wh_router_tb.sv
// wormhole router testbench
`timescale 1ns/1ps

module wh_router_tb;

  localparam logic [wh_pkg::X_W-1:0] LOCAL_X = 4'd5;
  localparam int NUM_ENTRIES = 20;
  localparam int NUM_QUEUES = wh_pkg::NUM_DIRS * wh_pkg::NUM_DIRS;
  localparam int FLIT_TIMEOUT = 1000;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam int RESET_TIMEOUT = 100;

  // one entry per packet with src 0 for P, 1 for W and 2 for E
  typedef struct packed {
    logic [3:0] test;
    logic [1:0] src;
    logic [3:0] dest_x;
    logic [3:0] len;
    logic [5:0] seed;
    logic       bp;
  } pkt_entry_t;

  logic              clk;
  logic              arst_n;
  wh_pkg::dir_mask_t in_valid;
  wh_pkg::flit_vec_t in_data;
  wh_pkg::dir_mask_t in_ready;
  wh_pkg::dir_mask_t out_valid;
  wh_pkg::flit_vec_t out_data;
  wh_pkg::dir_mask_t out_ready;
  wh_pkg::dir_mask_t bp_en;
  pkt_entry_t        pkt_table [NUM_ENTRIES];
  wh_pkg::flit_t     exp_q [NUM_QUEUES][$];
  int                rem [wh_pkg::NUM_DIRS];
  int                cur_src [wh_pkg::NUM_DIRS];
  int                errors;
  int                tests_run;
  int                tests_failed;
  bit                hung;

  wh_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  wh_router_1d u_wh_router_1d (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .local_x_i   (LOCAL_X),
    .in_valid_i  (in_valid),
    .in_data_i   (in_data),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_data_o  (out_data),
    .out_ready_i (out_ready)
  );

  bind wh_output_port wh_router_asserts #(
    .PORT (PORT)
  ) u_asserts (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_i  (out_data_o),
    .grant_i     (grant_o)
  );

  // x routing of this node
  function automatic int route_of(input logic [wh_pkg::X_W-1:0] dest_x);
    if (dest_x == LOCAL_X) begin
      return wh_pkg::DIR_P;
    end else if (dest_x < LOCAL_X) begin
      return wh_pkg::DIR_W;
    end
    return wh_pkg::DIR_E;
  endfunction

  task automatic note_timeout(input string why);
    $display("%s", why);
    errors++;
    hung = 1'b1;
  endtask

  // starts on a rising edge and returns on the edge of the transfer
  task automatic push_flit(input int src, input wh_pkg::flit_t f);
    bit done;
    in_valid[src] <= 1'b1;
    in_data[src]  <= f;
    done = 1'b0;
    for (int c = 0; c < FLIT_TIMEOUT && !done && !hung; c++) begin
      @(negedge clk);
      done = in_ready[src];
      @(posedge clk);
    end
    if (!done && !hung) begin
      note_timeout($sformatf("input %0d never accepted a flit", src));
    end
  endtask

  task automatic drive_source(input int src, input int test);
    int out;
    wh_pkg::flit_t f;
    for (int e = 0; e < NUM_ENTRIES && !hung; e++) begin
      if (int'(pkt_table[e].test) == test && int'(pkt_table[e].src) == src) begin
        out = route_of(pkt_table[e].dest_x);
        for (int k = 0; k <= int'(pkt_table[e].len) && !hung; k++) begin
          if (k == 0) begin
            f.dest_x  = pkt_table[e].dest_x;
            f.len     = pkt_table[e].len;
            // source id in the top payload bits
            f.payload = {2'(src), pkt_table[e].seed};
          end else begin
            f = 16'($urandom);
          end
          exp_q[out * wh_pkg::NUM_DIRS + src].push_back(f);
          push_flit(src, f);
        end
      end
    end
    in_valid[src] <= 1'b0;
  endtask

  // the header picks the source queue and body flits follow it
  function automatic void check_flit(input int o, input wh_pkg::flit_t f);
    int q;
    wh_pkg::flit_t expected;
    if (rem[o] == 0) begin
      cur_src[o] = int'(f.payload[wh_pkg::PAYLOAD_W-1 -: 2]);
    end
    q = o * wh_pkg::NUM_DIRS + cur_src[o];
    if (cur_src[o] >= wh_pkg::NUM_DIRS) begin
      $display("output %0d sent a header from no known source", o);
      errors++;
    end else if (exp_q[q].size() == 0) begin
      $display("output %0d sent a flit that was never sent to it", o);
      errors++;
    end else begin
      expected = exp_q[q].pop_front();
      if (f !== expected) begin
        $display("FAILED out_data_o[%0d]: got 0x%h, expected 0x%h", o, f, expected);
        errors++;
      end
    end
    rem[o] = (rem[o] == 0) ? int'(f.len) : rem[o] - 1;
  endfunction

  function automatic bit queues_empty();
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (exp_q[q].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic report_test(input int id, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %0d: failed with %0d errors", id, errors - err_before);
    end else begin
      $display("test %0d: ok", id);
    end
  endtask

  // monitor samples settled values at the falling edge
  always @(negedge clk) begin
    for (int o = 0; o < wh_pkg::NUM_DIRS; o++) begin
      if (arst_n && out_valid[o] && out_ready[o]) begin
        check_flit(o, out_data[o]);
      end
    end
  end

  // random stalls with ready three cycles in four
  always @(posedge clk) begin
    for (int o = 0; o < wh_pkg::NUM_DIRS; o++) begin
      out_ready[o] <= bp_en[o] ? ($urandom_range(3, 0) != 0) : 1'b1;
    end
  end

  initial begin
    int t;
    int e;
    int err_before;
    bit drained;
    void'($urandom(32'he65a_80ed));
    in_valid <= '0;
    in_data <= '0;
    out_ready <= '1;
    bp_en = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    hung = 1'b0;
    rem = '{default: 0};
    cur_src = '{default: 0};
    // test, src, dest_x, len, seed, back-pressure
    pkt_table = '{
      '{4'd1, 2'd0, 4'd3, 4'd2, 6'h01, 1'b0}, '{4'd1, 2'd0, 4'd5, 4'd1, 6'h02, 1'b0},
      '{4'd1, 2'd0, 4'd9, 4'd3, 6'h03, 1'b0}, '{4'd2, 2'd1, 4'd5, 4'd2, 6'h04, 1'b0},
      '{4'd2, 2'd1, 4'd12, 4'd1, 6'h05, 1'b0}, '{4'd2, 2'd2, 4'd1, 4'd2, 6'h06, 1'b0},
      '{4'd2, 2'd2, 4'd5, 4'd0, 6'h07, 1'b0}, '{4'd3, 2'd0, 4'd5, 4'd3, 6'h08, 1'b0},
      '{4'd3, 2'd1, 4'd7, 4'd2, 6'h09, 1'b0}, '{4'd4, 2'd0, 4'd2, 4'd9, 6'h0a, 1'b0},
      '{4'd4, 2'd2, 4'd0, 4'd9, 6'h0b, 1'b0}, '{4'd5, 2'd0, 4'd5, 4'd12, 6'h0c, 1'b0},
      '{4'd5, 2'd1, 4'd5, 4'd12, 6'h0d, 1'b0}, '{4'd5, 2'd2, 4'd5, 4'd12, 6'h0e, 1'b0},
      '{4'd6, 2'd0, 4'd0, 4'd4, 6'h10, 1'b1}, '{4'd6, 2'd1, 4'd9, 4'd5, 6'h11, 1'b1},
      '{4'd6, 2'd2, 4'd5, 4'd3, 6'h12, 1'b1}, '{4'd6, 2'd0, 4'd8, 4'd0, 6'h13, 1'b1},
      '{4'd6, 2'd2, 4'd2, 4'd0, 6'h14, 1'b1}, '{4'd6, 2'd1, 4'd5, 4'd0, 6'h15, 1'b1}
    };
    err_before = errors;
    for (int c = 0; c < RESET_TIMEOUT && arst_n !== 1'b1; c++) begin
      @(posedge clk);
    end
    if (arst_n !== 1'b1) begin
      note_timeout("reset was never released");
    end
    @(negedge clk);
    if (out_valid !== 3'b000) begin
      $display("FAILED out_valid_o: got 0x%h, expected 0x0", out_valid);
      errors++;
    end
    if (in_ready !== 3'b111) begin
      $display("FAILED in_ready_o: got 0x%h, expected 0x7", in_ready);
      errors++;
    end
    report_test(0, err_before);
    e = 0;
    while (e < NUM_ENTRIES && !hung) begin
      t = int'(pkt_table[e].test);
      err_before = errors;
      bp_en = '0;
      for (int k = e; k < NUM_ENTRIES; k++) begin
        if (int'(pkt_table[k].test) == t && pkt_table[k].bp) begin
          bp_en[route_of(pkt_table[k].dest_x)] = 1'b1;
        end
      end
      @(posedge clk);
      fork
        drive_source(wh_pkg::DIR_P, t);
        drive_source(wh_pkg::DIR_W, t);
        drive_source(wh_pkg::DIR_E, t);
      join
      drained = 1'b0;
      for (int c = 0; c < DRAIN_TIMEOUT && !drained && !hung; c++) begin
        @(posedge clk);
        drained = queues_empty();
      end
      if (!drained && !hung) begin
        note_timeout($sformatf("test %0d: flits never left the router", t));
      end
      report_test(t, err_before);
      while (e < NUM_ENTRIES && int'(pkt_table[e].test) == t) begin
        e++;
      end
    end
    $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- files.f
common/wh_pkg.sv
hdl/wh_two_fifo.sv
wh_input/wh_input_port.sv
wh_output/wh_rr_arb.sv
wh_output/wh_output_port.sv
hdl/wh_router_1d.sv
tests/wh_clk_gen.sv
tests/wh_router_asserts.sv
tests/wh_router_tb.sv

//--- Makefile
SIM  := obj_dir/Vwh_router_tb
SRCS := $(shell grep -v '^+' files.f)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f \
	  --top-module wh_router_tb -o Vwh_router_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
